// ==== rtl/proc_pkg.sv ====
// Word types, opcodes, ALU and forwarding codes, APB map, run states and pipeline registers
package proc_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;
   typedef logic [4:0]  opcode_t;
   typedef logic [1:0]  alu_op_t;
   typedef logic        wb_sel_t;
   typedef logic [1:0]  fwd_sel_t;
   typedef logic [9:0]  apb_addr_t;

   // Opcodes in instruction bits 15 to 11
   localparam opcode_t OP_HALT  = 5'b00000;
   localparam opcode_t OP_NOP   = 5'b00001;
   localparam opcode_t OP_ADDI  = 5'b01000;
   localparam opcode_t OP_LBI   = 5'b11000;
   localparam opcode_t OP_ST    = 5'b10000;
   localparam opcode_t OP_LD    = 5'b10001;
   localparam opcode_t OP_BEQZ  = 5'b01100;
   localparam opcode_t OP_J     = 5'b00100;
   localparam opcode_t OP_RTYPE = 5'b11011;

   // R-type function in instruction bits 1 to 0
   localparam alu_op_t ALU_ADD  = 2'b00;
   localparam alu_op_t ALU_SUB  = 2'b01;   // Rs - Rt
   localparam alu_op_t ALU_XOR  = 2'b10;
   localparam alu_op_t ALU_ANDN = 2'b11;   // Rs & ~Rt

   localparam wb_sel_t WB_ALU = 1'b0;
   localparam wb_sel_t WB_MEM = 1'b1;

   localparam fwd_sel_t FWD_RF  = 2'd0;
   localparam fwd_sel_t FWD_MEM = 2'd1;
   localparam fwd_sel_t FWD_WB  = 2'd2;

   // Debug port map
   localparam apb_addr_t ADDR_DMEM = 10'h200;
   localparam apb_addr_t ADDR_CTRL = 10'h3FE;
   localparam apb_addr_t ADDR_STAT = 10'h3FF;

   typedef enum logic [1:0] {
      RUN_IDLE,
      RUN_ACTIVE,
      RUN_HALTED,
      RUN_ERROR
   } run_state_e;

   typedef struct packed {
      logic  valid;
      word_t instr;
      word_t pc_inc;
   } if_id_t;

   typedef struct packed {
      logic     valid;
      word_t    op_a;
      word_t    op_b;
      reg_idx_t src_a;
      reg_idx_t src_b;
      logic     uses_b;
      word_t    imm;
      alu_op_t  alu_op;
      logic     use_imm;
      logic     lbi;
      logic     branch;
      logic     jump;
      logic     halt;
      logic     illegal;
      logic     mem_rd;
      logic     mem_wr;
      logic     reg_we;
      reg_idx_t dst;
      wb_sel_t  wb_sel;
      word_t    pc_inc;
   } id_ex_t;

   typedef struct packed {
      logic     valid;
      word_t    result;
      word_t    store_data;
      logic     mem_rd;
      logic     mem_wr;
      logic     reg_we;
      reg_idx_t dst;
      wb_sel_t  wb_sel;
      logic     halt;
   } ex_mem_t;

   typedef struct packed {
      logic     valid;
      logic     we;
      reg_idx_t dst;
      word_t    wdata;
      logic     halt;
   } mem_wb_t;

endpackage

// ==== rtl/fetch.sv ====
// Fetch stage with program counter, instruction memory and fetch-to-decode register
module fetch #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          run,
   input  logic                          stall,
   input  logic                          redirect,
   input  proc_pkg::word_t               target,
   input  logic                          imem_we,
   input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
   input  proc_pkg::word_t               imem_wdata,
   output proc_pkg::if_id_t              if_id
);
   import proc_pkg::*;

   localparam int IA = $clog2(IMEM_WORDS);

   word_t imem [IMEM_WORDS];
   word_t pc;
   word_t pc_inc;
   word_t instr;

   // Byte addressed PC, one instruction per even address
   assign pc_inc = pc + 16'd2;
   assign instr  = imem[pc[IA:1]];

   // Loaded by the debug port only
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc    <= '0;
         if_id <= '0;
      end else if (!run) begin
         // Stopped core restarts from address zero
         pc          <= '0;
         if_id.valid <= 1'b0;
      end else if (redirect) begin
         pc          <= target;
         if_id.valid <= 1'b0;
      end else if (!stall) begin
         pc           <= pc_inc;
         if_id.valid  <= 1'b1;
         if_id.instr  <= instr;
         if_id.pc_inc <= pc_inc;
      end
   end

endmodule

// ==== rtl/decode.sv ====
// Decode stage with instruction decoder, register file and decode-to-execute register
module decode (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               run,
   input  logic               stall,
   input  logic               flush,
   input  proc_pkg::if_id_t   if_id,
   input  proc_pkg::mem_wb_t  wb,
   output proc_pkg::id_ex_t   id_ex,
   output proc_pkg::reg_idx_t src_a,
   output proc_pkg::reg_idx_t src_b,
   output logic               uses_b
);
   import proc_pkg::*;

   word_t   rf [8];
   word_t   rd_a;
   word_t   rd_b;
   opcode_t op;
   id_ex_t  nxt;

   assign op     = if_id.instr[15:11];
   assign src_a  = if_id.instr[10:8];
   assign src_b  = if_id.instr[7:5];
   assign uses_b = (op == OP_RTYPE) || (op == OP_ST);

   // Writeback bypass into the read ports
   assign rd_a = (wb.valid && wb.we && wb.dst == src_a) ? wb.wdata : rf[src_a];
   assign rd_b = (wb.valid && wb.we && wb.dst == src_b) ? wb.wdata : rf[src_b];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rf <= '{default: '0};
      end else if (wb.valid && wb.we) begin
         rf[wb.dst] <= wb.wdata;
      end
   end

   always_comb begin
      nxt        = '0;
      // Bubble on stall or flush
      nxt.valid  = if_id.valid && run && !stall && !flush;
      nxt.op_a   = rd_a;
      nxt.op_b   = rd_b;
      nxt.src_a  = src_a;
      nxt.src_b  = src_b;
      nxt.uses_b = uses_b;
      nxt.imm    = {{11{if_id.instr[4]}}, if_id.instr[4:0]};
      nxt.alu_op = ALU_ADD;
      nxt.wb_sel = WB_ALU;
      nxt.pc_inc = if_id.pc_inc;
      case (op)
         OP_HALT: nxt.halt = 1'b1;
         OP_NOP: ;
         OP_ADDI: begin
            nxt.use_imm = 1'b1;
            nxt.reg_we  = 1'b1;
            nxt.dst     = if_id.instr[7:5];
         end
         OP_LBI: begin
            nxt.lbi    = 1'b1;
            nxt.reg_we = 1'b1;
            nxt.dst    = if_id.instr[10:8];
            nxt.imm    = {{8{if_id.instr[7]}}, if_id.instr[7:0]};
         end
         OP_ST: begin
            // Base in Rs, data in bits 7 to 5
            nxt.use_imm = 1'b1;
            nxt.mem_wr  = 1'b1;
         end
         OP_LD: begin
            nxt.use_imm = 1'b1;
            nxt.mem_rd  = 1'b1;
            nxt.reg_we  = 1'b1;
            nxt.dst     = if_id.instr[7:5];
            nxt.wb_sel  = WB_MEM;
         end
         OP_BEQZ: begin
            nxt.branch = 1'b1;
            nxt.imm    = {{8{if_id.instr[7]}}, if_id.instr[7:0]};
         end
         OP_J: begin
            nxt.jump = 1'b1;
            nxt.imm  = {{5{if_id.instr[10]}}, if_id.instr[10:0]};
         end
         OP_RTYPE: begin
            nxt.reg_we = 1'b1;
            nxt.dst    = if_id.instr[4:2];
            nxt.alu_op = if_id.instr[1:0];
         end
         default: nxt.illegal = 1'b1;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ex <= '0;
      end else begin
         id_ex <= nxt;
      end
   end

endmodule

// ==== rtl/execute.sv ====
// Execute stage with operand forwarding, ALU, branch resolution and execute-to-memory register
module execute (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               run,
   input  proc_pkg::id_ex_t   id_ex,
   input  proc_pkg::fwd_sel_t fwd_a,
   input  proc_pkg::fwd_sel_t fwd_b,
   input  proc_pkg::word_t    mem_fwd,
   input  proc_pkg::word_t    wb_fwd,
   output proc_pkg::ex_mem_t  ex_mem,
   output logic               redirect,
   output proc_pkg::word_t    target,
   output logic               illegal_seen
);
   import proc_pkg::*;

   word_t a;
   word_t b;
   word_t alu_b;
   word_t alu_out;
   logic  live;
   logic  stop_q;

   function automatic word_t pick(fwd_sel_t sel, word_t rf_val, word_t mem_val,
                                  word_t wb_val);
      case (sel)
         FWD_MEM: return mem_val;
         FWD_WB:  return wb_val;
         default: return rf_val;
      endcase
   endfunction

   assign a     = pick(fwd_a, id_ex.op_a, mem_fwd, wb_fwd);
   assign b     = pick(fwd_b, id_ex.op_b, mem_fwd, wb_fwd);
   assign alu_b = id_ex.use_imm ? id_ex.imm : b;

   always_comb begin
      case (id_ex.alu_op)
         ALU_SUB:  alu_out = a - alu_b;
         ALU_XOR:  alu_out = a ^ alu_b;
         ALU_ANDN: alu_out = a & ~alu_b;
         default:  alu_out = a + alu_b;
      endcase
   end

   // Nothing younger than a halt or an illegal opcode passes here
   assign live         = id_ex.valid && !stop_q;
   assign illegal_seen = live && id_ex.illegal;

   // Targets relative to the incremented PC
   assign redirect = live && (id_ex.jump || (id_ex.branch && a == '0));
   assign target   = id_ex.pc_inc + id_ex.imm;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stop_q <= 1'b0;
         ex_mem <= '0;
      end else begin
         if (!run) begin
            stop_q <= 1'b0;
         end else if (live && (id_ex.halt || id_ex.illegal)) begin
            stop_q <= 1'b1;
         end
         ex_mem.valid      <= run && live && !id_ex.illegal;
         ex_mem.result     <= id_ex.lbi ? id_ex.imm : alu_out;
         ex_mem.store_data <= b;
         ex_mem.mem_rd     <= id_ex.mem_rd;
         ex_mem.mem_wr     <= id_ex.mem_wr;
         ex_mem.reg_we     <= id_ex.reg_we;
         ex_mem.dst        <= id_ex.dst;
         ex_mem.wb_sel     <= id_ex.wb_sel;
         ex_mem.halt       <= id_ex.halt;
      end
   end

endmodule

// ==== rtl/memory.sv ====
// Memory stage with shared data memory, memory-to-writeback register and writeback select
module memory #(
   parameter int DMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  proc_pkg::ex_mem_t             ex_mem,
   input  logic                          dbg_req,
   input  logic                          dbg_we,
   input  logic [$clog2(DMEM_WORDS)-1:0] dbg_addr,
   input  proc_pkg::word_t               dbg_wdata,
   output proc_pkg::word_t               dbg_rdata,
   output proc_pkg::word_t               mem_fwd,
   output proc_pkg::mem_wb_t             mem_wb,
   output logic                          halt_done
);
   import proc_pkg::*;

   localparam int DA = $clog2(DMEM_WORDS);

   word_t         dmem [DMEM_WORDS];
   word_t         rdata_q;
   mem_wb_t       wb_q;
   wb_sel_t       sel_q;
   logic [DA-1:0] idx;
   logic          mem_we;
   word_t         mem_wdata;

   // Debug port owns the memory while the core is stopped
   assign idx       = dbg_req ? dbg_addr : ex_mem.result[DA:1];
   assign mem_we    = dbg_req ? dbg_we : (ex_mem.valid && ex_mem.mem_wr);
   assign mem_wdata = dbg_req ? dbg_wdata : ex_mem.store_data;

   always_ff @(posedge clk) begin
      if (mem_we) begin
         dmem[idx] <= mem_wdata;
      end
      if (dbg_req || (ex_mem.valid && ex_mem.mem_rd)) begin
         rdata_q <= dmem[idx];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_q  <= '0;
         sel_q <= WB_ALU;
      end else begin
         wb_q.valid <= ex_mem.valid;
         wb_q.we    <= ex_mem.valid && ex_mem.reg_we;
         wb_q.dst   <= ex_mem.dst;
         wb_q.wdata <= ex_mem.result;
         wb_q.halt  <= ex_mem.valid && ex_mem.halt;
         sel_q      <= ex_mem.wb_sel;
      end
   end

   // Load data only exists after the synchronous read
   always_comb begin
      mem_wb = wb_q;
      if (sel_q == WB_MEM) begin
         mem_wb.wdata = rdata_q;
      end
   end

   assign dbg_rdata = rdata_q;
   assign mem_fwd   = ex_mem.result;
   assign halt_done = mem_wb.valid && mem_wb.halt;

endmodule

// ==== rtl/hazard.sv ====
// Forwarding select and load-use stall detection
module hazard (
   input  proc_pkg::reg_idx_t src_a,
   input  proc_pkg::reg_idx_t src_b,
   input  logic               uses_b,
   input  proc_pkg::id_ex_t   id_ex,
   input  proc_pkg::ex_mem_t  ex_mem,
   input  proc_pkg::mem_wb_t  mem_wb,
   output proc_pkg::fwd_sel_t fwd_a,
   output proc_pkg::fwd_sel_t fwd_b,
   output logic               stall
);
   import proc_pkg::*;

   // Youngest valid writer wins
   function automatic fwd_sel_t fwd_from(reg_idx_t src, ex_mem_t m, mem_wb_t w);
      if (m.valid && m.reg_we && m.dst == src) begin
         return FWD_MEM;
      end else if (w.valid && w.we && w.dst == src) begin
         return FWD_WB;
      end
      return FWD_RF;
   endfunction

   assign fwd_a = fwd_from(id_ex.src_a, ex_mem, mem_wb);
   assign fwd_b = id_ex.uses_b ? fwd_from(id_ex.src_b, ex_mem, mem_wb) : FWD_RF;

   // Load in execute whose result decode needs next cycle
   assign stall = id_ex.valid && id_ex.mem_rd &&
                  (id_ex.dst == src_a || (uses_b && id_ex.dst == src_b));

endmodule

// ==== rtl/apb_debug.sv ====
// APB debug slave with memory load and readback, start control, status and run FSM
module apb_debug #(
   parameter int IMEM_WORDS = 256,
   parameter int DMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  proc_pkg::apb_addr_t           paddr,
   input  proc_pkg::word_t               pwdata,
   output proc_pkg::word_t               prdata,
   output logic                          pready,
   output logic                          pslverr,
   output logic                          halted,
   output logic                          err,
   input  logic                          halt_done,
   input  logic                          illegal_seen,
   output logic                          run,
   output logic                          imem_we,
   output logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
   output proc_pkg::word_t               imem_wdata,
   output logic                          dbg_req,
   output logic                          dbg_we,
   output logic [$clog2(DMEM_WORDS)-1:0] dbg_addr,
   output proc_pkg::word_t               dbg_wdata,
   input  proc_pkg::word_t               dbg_rdata
);
   import proc_pkg::*;

   localparam int IA = $clog2(IMEM_WORDS);
   localparam int DA = $clog2(DMEM_WORDS);

   run_state_e state;
   logic       access;
   logic       wait_q;
   logic       start;
   logic       is_imem;
   logic       is_dmem;
   logic       is_ctrl;
   logic       is_stat;
   logic       bad;
   logic       dmem_read;

   assign access  = psel && penable;
   assign is_imem = paddr < ADDR_DMEM;
   assign is_dmem = paddr >= ADDR_DMEM && paddr < ADDR_CTRL;
   assign is_ctrl = paddr == ADDR_CTRL;
   assign is_stat = paddr == ADDR_STAT;

   // Refused accesses
   assign bad = ((is_imem || is_dmem) && (run || paddr[0])) ||
                (is_imem && !pwrite) || (is_stat && pwrite);

   // Data memory reads take one wait state
   assign dmem_read = is_dmem && !pwrite && !bad;
   assign pready    = access && (!dmem_read || wait_q);
   assign pslverr   = pready && bad;
   assign prdata    = is_stat ? {14'd0, err, halted} : (is_dmem ? dbg_rdata : '0);

   assign imem_we    = access && pwrite && is_imem && !bad;
   assign imem_addr  = paddr[IA:1];
   assign imem_wdata = pwdata;
   assign dbg_req    = access && is_dmem && !bad;
   assign dbg_we     = pwrite;
   assign dbg_addr   = paddr[DA:1];
   assign dbg_wdata  = pwdata;
   assign start      = access && pwrite && is_ctrl && pwdata[0];

   assign run    = state == RUN_ACTIVE;
   assign halted = state == RUN_HALTED || state == RUN_ERROR;
   assign err    = state == RUN_ERROR;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= RUN_IDLE;
         wait_q <= 1'b0;
      end else begin
         wait_q <= access && !pready;
         case (state)
            RUN_ACTIVE: begin
               // Illegal opcode wins over a later halt
               if (illegal_seen) begin
                  state <= RUN_ERROR;
               end else if (halt_done) begin
                  state <= RUN_HALTED;
               end
            end
            default: begin
               // Idle, halted or error
               if (start) begin
                  state <= RUN_ACTIVE;
               end
            end
         endcase
      end
   end

endmodule

// ==== rtl/proc.sv ====
// Processor top level joining pipeline stages, hazard unit and APB debug port
module proc #(
   parameter int IMEM_WORDS = 256,
   parameter int DMEM_WORDS = 256
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  proc_pkg::apb_addr_t paddr,
   input  proc_pkg::word_t     pwdata,
   output proc_pkg::word_t     prdata,
   output logic                pready,
   output logic                pslverr,
   output logic                halted,
   output logic                err
);
   import proc_pkg::*;

   logic                          run;
   logic                          stall;
   logic                          redirect;
   logic                          illegal_seen;
   logic                          halt_done;
   word_t                         target;
   logic                          imem_we;
   logic [$clog2(IMEM_WORDS)-1:0] imem_addr;
   word_t                         imem_wdata;
   logic                          dbg_req;
   logic                          dbg_we;
   logic [$clog2(DMEM_WORDS)-1:0] dbg_addr;
   word_t                         dbg_wdata;
   word_t                         dbg_rdata;
   word_t                         mem_fwd;
   reg_idx_t                      src_a;
   reg_idx_t                      src_b;
   logic                          uses_b;
   fwd_sel_t                      fwd_a;
   fwd_sel_t                      fwd_b;
   if_id_t                        if_id;
   id_ex_t                        id_ex;
   ex_mem_t                       ex_mem;
   mem_wb_t                       mem_wb;

   apb_debug #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) apb_debug0 (
      .clk(clk), .arst_n(arst_n),
      .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
      .pready(pready), .pslverr(pslverr),
      .halted(halted), .err(err),
      .halt_done(halt_done), .illegal_seen(illegal_seen), .run(run),
      .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
      .dbg_req(dbg_req), .dbg_we(dbg_we), .dbg_addr(dbg_addr),
      .dbg_wdata(dbg_wdata), .dbg_rdata(dbg_rdata)
   );

   fetch #(.IMEM_WORDS(IMEM_WORDS)) fetch0 (
      .clk(clk), .arst_n(arst_n), .run(run), .stall(stall),
      .redirect(redirect), .target(target),
      .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
      .if_id(if_id)
   );

   // A taken branch or jump flushes the instruction in decode
   decode decode0 (
      .clk(clk), .arst_n(arst_n), .run(run), .stall(stall), .flush(redirect),
      .if_id(if_id), .wb(mem_wb), .id_ex(id_ex),
      .src_a(src_a), .src_b(src_b), .uses_b(uses_b)
   );

   execute execute0 (
      .clk(clk), .arst_n(arst_n), .run(run), .id_ex(id_ex),
      .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_fwd(mem_fwd), .wb_fwd(mem_wb.wdata),
      .ex_mem(ex_mem), .redirect(redirect), .target(target),
      .illegal_seen(illegal_seen)
   );

   memory #(.DMEM_WORDS(DMEM_WORDS)) memory0 (
      .clk(clk), .arst_n(arst_n), .ex_mem(ex_mem),
      .dbg_req(dbg_req), .dbg_we(dbg_we), .dbg_addr(dbg_addr),
      .dbg_wdata(dbg_wdata), .dbg_rdata(dbg_rdata),
      .mem_fwd(mem_fwd), .mem_wb(mem_wb), .halt_done(halt_done)
   );

   hazard hazard0 (
      .src_a(src_a), .src_b(src_b), .uses_b(uses_b),
      .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
      .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
   );

endmodule

// ==== test/proc_checker.sv ====
// Bound assertions on the APB wait state and on squashing after a halt or illegal opcode
module proc_checker (
   input logic              clk,
   input logic              arst_n,
   input logic              psel,
   input logic              penable,
   input logic              pready,
   input logic              halted,
   input logic              halt_done,
   input logic              illegal_seen,
   input proc_pkg::ex_mem_t ex_mem
);

   // Single wait state at most
   assert property (@(posedge clk) disable iff (!arst_n) psel && penable && !pready |=> pready)
      else $error("APB transfer held more than one wait state");

   // Nothing younger than the stopping instruction reaches the memory stage
   assert property (@(posedge clk) disable iff (!arst_n) halted |-> !ex_mem.valid)
      else $error("valid instruction in the memory stage while halted");

   assert property (@(posedge clk) disable iff (!arst_n) !(illegal_seen && halt_done))
      else $error("illegal opcode and halt completed in the same cycle");

endmodule

bind proc proc_checker checker0 (
   .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pready(pready),
   .halted(halted), .halt_done(halt_done), .illegal_seen(illegal_seen), .ex_mem(ex_mem)
);

// ==== test/proc_tb.sv ====
// Testbench with APB tasks, program builders, ISA reference model and memory comparison
module proc_tb;
   import proc_pkg::*;

   localparam int MAX_LEN    = 32;
   localparam int PAD        = 4;
   localparam int LOOP_BOUND = 4;
   localparam int STEP_LIMIT = 2000;
   localparam int NUM_TESTS  = 25;
   localparam int DWORDS     = 255;
   // APB transfers per test, four cycles each plus the read wait
   localparam int APB_CYCLES = (MAX_LEN + PAD + 3 * DWORDS + 4) * 5;
   localparam int WATCHDOG   = NUM_TESTS * (20 * MAX_LEN * LOOP_BOUND + APB_CYCLES);

   logic      clk;
   logic      arst_n;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   word_t     pwdata;
   word_t     prdata;
   logic      pready;
   logic      pslverr;
   logic      halted;
   logic      err;

   word_t prog[$];
   word_t m_rf [8];
   word_t m_mem [256];
   int    errors;
   int    tests;
   int    failed;
   int    seed;
   string cur_test;

   proc UUT (
      .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("timeout: core or APB port did not respond in time");
      $display(">>> FAIL");
      $finish;
   end

   // Instruction encoders
   function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic word_t enc_lbi(reg_idx_t rd, logic [7:0] imm);
      return {OP_LBI, rd, imm};
   endfunction

   function automatic word_t enc_beqz(reg_idx_t rs, logic [7:0] imm);
      return {OP_BEQZ, rs, imm};
   endfunction

   function automatic word_t enc_j(logic [10:0] imm);
      return {OP_J, imm};
   endfunction

   function automatic word_t enc_rr(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, alu_op_t fn);
      return {OP_RTYPE, rs, rt, rd, fn};
   endfunction

   function automatic word_t fill_word(int i);
      return word_t'(i * 40503) ^ 16'h6b3d ^ word_t'(i << 8);
   endfunction

   // Sequential ISA model, returns 1 on an illegal opcode
   function automatic bit iss_run(input int n);
      word_t pc;
      word_t ins;
      word_t a;
      word_t b;
      word_t ea;
      word_t nxt;
      pc = '0;
      for (int steps = 0; steps < STEP_LIMIT; steps++) begin
         if (int'(pc[8:1]) >= n) begin
            return 1'b0;
         end
         ins = prog[pc[8:1]];
         a   = m_rf[ins[10:8]];
         b   = m_rf[ins[7:5]];
         ea  = a + {{11{ins[4]}}, ins[4:0]};
         nxt = pc + 16'd2;
         case (ins[15:11])
            OP_HALT: return 1'b0;
            OP_NOP: ;
            OP_ADDI: m_rf[ins[7:5]] = ea;
            OP_LBI: m_rf[ins[10:8]] = {{8{ins[7]}}, ins[7:0]};
            OP_ST: m_mem[ea[8:1]] = b;
            OP_LD: m_rf[ins[7:5]] = m_mem[ea[8:1]];
            OP_BEQZ: begin
               if (a == 16'd0) begin
                  nxt = nxt + {{8{ins[7]}}, ins[7:0]};
               end
            end
            OP_J: nxt = nxt + {{5{ins[10]}}, ins[10:0]};
            OP_RTYPE: begin
               case (ins[1:0])
                  2'd0: m_rf[ins[4:2]] = a + b;
                  2'd1: m_rf[ins[4:2]] = a - b;
                  2'd2: m_rf[ins[4:2]] = a ^ b;
                  default: m_rf[ins[4:2]] = a & ~b;
               endcase
            end
            default: return 1'b1;
         endcase
         pc = nxt;
      end
      return 1'b1;
   endfunction

   task automatic apb_xfer(input bit wr, input apb_addr_t addr, input word_t wdata,
                           input bit exp_err, output word_t rdata);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #25;
      while (!pready) begin
         @(negedge clk);
         #25;
      end
      rdata = prdata;
      if (pslverr !== exp_err) begin
         $display("mismatch %s pslverr at address %h: expected %b, actual %b",
                  cur_test, addr, exp_err, pslverr);
         errors++;
      end
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input word_t data, input bit exp_err);
      word_t unused;
      apb_xfer(1'b1, addr, data, exp_err, unused);
   endtask

   task automatic apb_read(input apb_addr_t addr, output word_t data, input bit exp_err);
      apb_xfer(1'b0, addr, 16'd0, exp_err, data);
   endtask

   // Load, run, then compare status and every data word with the model
   task automatic run_test(input string name, input bit busy_check);
      int    errs0;
      word_t rd;
      bit    exp_err;
      errs0    = errors;
      cur_test = name;
      for (int i = 0; i < prog.size() + PAD && i < 256; i++) begin
         apb_write(apb_addr_t'(2 * i), (i < prog.size()) ? prog[i] : 16'h0000, 1'b0);
      end
      for (int i = 0; i < DWORDS; i++) begin
         m_mem[i] = fill_word(i);
         apb_write(apb_addr_t'(ADDR_DMEM + apb_addr_t'(2 * i)), m_mem[i], 1'b0);
      end
      exp_err = iss_run(prog.size());
      apb_write(ADDR_CTRL, 16'd1, 1'b0);
      if (busy_check) begin
         apb_read(ADDR_DMEM, rd, 1'b1);
      end
      do @(negedge clk); while (!halted);
      if (err !== exp_err) begin
         $display("mismatch %s err: expected %b, actual %b", name, exp_err, err);
         errors++;
      end
      apb_read(ADDR_STAT, rd, 1'b0);
      if (rd[1:0] !== {exp_err, 1'b1}) begin
         $display("mismatch %s status: expected %h, actual %h", name, {exp_err, 1'b1}, rd[1:0]);
         errors++;
      end
      for (int i = 0; i < DWORDS; i++) begin
         apb_read(apb_addr_t'(ADDR_DMEM + apb_addr_t'(2 * i)), rd, 1'b0);
         if (rd !== m_mem[i]) begin
            $display("mismatch %s word %0d: expected %h, actual %h", name, i, m_mem[i], rd);
            errors++;
         end
      end
      tests++;
      if (errors == errs0) begin
         $display("test %s: ok", name);
      end else begin
         failed++;
         $display("test %s: failed with %0d errors", name, errors - errs0);
      end
   endtask

   // Forward-only control flow keeps every random program finite
   task automatic build_random();
      int kind;
      int k;
      prog.delete();
      prog.push_back(enc_lbi(3'd7, 8'(40 + 2 * ($unsigned($random(seed)) % 31))));
      for (int i = 1; i < 23; i++) begin
         kind = $unsigned($random(seed)) % 8;
         k    = $unsigned($random(seed)) % (((22 - i) < 7 ? (22 - i) : 7) + 1);
         case (kind)
            0: prog.push_back(enc_lbi(3'($unsigned($random(seed)) % 7), 8'($random(seed))));
            1: prog.push_back(enc_i(OP_ADDI, 3'($random(seed)),
                                    3'($unsigned($random(seed)) % 7), 5'($random(seed))));
            2, 3: prog.push_back(enc_rr(3'($random(seed)), 3'($random(seed)),
                                        3'($unsigned($random(seed)) % 7), 2'($random(seed))));
            4: prog.push_back(enc_i(OP_ST, 3'd7, 3'($random(seed)), 5'($random(seed))));
            5: prog.push_back(enc_i(OP_LD, 3'd7, 3'($unsigned($random(seed)) % 7),
                                    5'($random(seed))));
            6: prog.push_back(enc_beqz(3'($random(seed)), 8'(2 * k)));
            default: prog.push_back(enc_j(11'(2 * k)));
         endcase
      end
      prog.push_back(16'h0000);
   endtask

   initial begin
      seed    = 32'h17c07ca1;
      errors  = 0;
      tests   = 0;
      failed  = 0;
      m_rf    = '{default: '0};
      arst_n  = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      prog = {enc_lbi(3'd1, 8'd100), enc_lbi(3'd2, 8'hf9),
              enc_i(OP_ADDI, 3'd1, 3'd3, 5'd9), enc_rr(3'd1, 3'd2, 3'd4, ALU_SUB),
              enc_rr(3'd1, 3'd2, 3'd5, ALU_XOR), enc_rr(3'd1, 3'd2, 3'd6, ALU_ANDN),
              enc_lbi(3'd7, 8'd32), enc_i(OP_ST, 3'd7, 3'd3, 5'd0),
              enc_i(OP_ST, 3'd7, 3'd4, 5'd2), enc_i(OP_ST, 3'd7, 3'd5, 5'd4),
              enc_i(OP_ST, 3'd7, 3'd6, 5'd6), enc_rr(3'd3, 3'd4, 3'd0, ALU_ADD),
              enc_i(OP_ST, 3'd7, 3'd0, 5'd8), 16'h0000};
      run_test("arith", 1'b0);

      // Distances one and two
      prog = {enc_lbi(3'd1, 8'd5), enc_i(OP_ADDI, 3'd1, 3'd2, 5'd3),
              enc_i(OP_ADDI, 3'd2, 3'd3, 5'd1), enc_rr(3'd1, 3'd3, 3'd4, ALU_ADD),
              16'h0800, enc_i(OP_ADDI, 3'd4, 3'd5, 5'd2), enc_lbi(3'd6, 8'd48),
              enc_i(OP_ST, 3'd6, 3'd2, 5'd0), enc_i(OP_ST, 3'd6, 3'd3, 5'd2),
              enc_i(OP_ST, 3'd6, 3'd4, 5'd4), enc_i(OP_ST, 3'd6, 3'd5, 5'd6), 16'h0000};
      run_test("forward", 1'b0);

      prog = {enc_lbi(3'd1, 8'd80), enc_i(OP_LD, 3'd1, 3'd2, 5'd0),
              enc_i(OP_ADDI, 3'd2, 3'd3, 5'd1), enc_i(OP_ST, 3'd1, 3'd3, 5'd4),
              enc_i(OP_LD, 3'd1, 3'd4, 5'd2), enc_i(OP_ST, 3'd1, 3'd4, 5'd6),
              enc_rr(3'd4, 3'd2, 3'd5, ALU_ADD), enc_i(OP_ST, 3'd1, 3'd5, 5'd8), 16'h0000};
      run_test("load_use", 1'b0);

      // Counting loop, words after the jump and after the exit branch are skipped
      prog = {enc_lbi(3'd1, 8'd3), enc_lbi(3'd2, 8'd0), enc_lbi(3'd3, 8'd64),
              enc_beqz(3'd1, 8'd12), enc_i(OP_ADDI, 3'd2, 3'd2, 5'd5),
              enc_i(OP_ADDI, 3'd1, 3'd1, 5'h1f), enc_i(OP_ST, 3'd3, 3'd2, 5'd0),
              enc_j(11'h7f6), enc_lbi(3'd2, 8'd99), enc_lbi(3'd1, 8'd77),
              enc_i(OP_ST, 3'd3, 3'd2, 5'd2), enc_i(OP_ST, 3'd3, 3'd1, 5'd4), 16'h0000};
      run_test("loop", 1'b0);

      prog = {enc_lbi(3'd1, 8'd96), enc_lbi(3'd2, 8'd11), enc_i(OP_ST, 3'd1, 3'd2, 5'd0)};
      repeat (10) prog.push_back(16'h0800);
      prog.push_back(16'hf800);
      prog.push_back(enc_i(OP_ST, 3'd1, 3'd2, 5'd2));
      prog.push_back(16'h0000);
      run_test("illegal", 1'b1);

      for (int t = 0; t < 20; t++) begin
         build_random();
         run_test($sformatf("random_%0d", t), 1'b0);
      end

      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== proc.f ====
rtl/proc_pkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/hazard.sv
rtl/apb_debug.sv
rtl/proc.sv
test/proc_checker.sv
test/proc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= proc_tb
FILELIST  ?= proc.f
LOG       ?= sim.log
PASS_TEXT ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(FILELIST) rtl/*.sv test/*.sv
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
